/* mbus_macros.svh */
// MBus receive node widths and counts
// Byte size, synchronizer depth and interjection edge count shared by
// the sampler, the interjection detector and the frame decoder

`ifndef MBUS_MACROS_SVH
`define MBUS_MACROS_SVH

//////////////////////////////
// Frame format
//////////////////////////////

// Bits per address or data byte
`define MBUS_BYTE_W 8

// Bit position counter inside one byte
`define MBUS_BIT_CNT_W 3

//////////////////////////////
// Line sampling and interjection
//////////////////////////////

// Flops in each pin synchronizer
`define MBUS_SYNC_STAGES 2

// Alternating data edges while bus_clk is high
`define MBUS_INT_EDGES 6

// Wide enough to hold 0 to MBUS_INT_EDGES
`define MBUS_EDGE_CNT_W 3

`endif

/* mbus_pkg.sv */
// MBus receive node types
// Vector typedefs for bytes and counters, plus the frame decoder states

`default_nettype none

`include "mbus_macros.svh"

package mbus_pkg;

    //////////////////////////////
    // Data and counters
    //////////////////////////////

    // One address or data byte, MSB first on the wire
    typedef logic [`MBUS_BYTE_W-1:0] bus_byte_t;

    // Bit position in the byte being shifted in
    typedef logic [`MBUS_BIT_CNT_W-1:0] bit_cnt_t;

    // Qualifying interjection edges seen so far
    typedef logic [`MBUS_EDGE_CNT_W-1:0] edge_cnt_t;

    //////////////////////////////
    // Frame FSM
    //////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        ADDR,
        DATA,
        SKIP,
        WAIT_IDLE
    } rx_state_t;

endpackage

`default_nettype wire

/* mbus_line_if.sv */
// MBus sampled line group
// Synchronized bus_clk and bus_data levels with one-cycle edge strobes.
// Driven by the line sampler, read by the detector and the frame decoder

`timescale 1ns/1ps
`default_nettype none

interface mbus_line_if;

    // Synchronized levels, idle high
    logic clk_lvl;
    logic data_lvl;

    // Single-cycle strobes, aligned with the first new level
    logic clk_rise;
    logic data_rise;
    logic data_fall;

    modport source (
        output clk_lvl,
        output data_lvl,
        output clk_rise,
        output data_rise,
        output data_fall
    );

    modport sink (
        input clk_lvl,
        input data_lvl,
        input clk_rise,
        input data_rise,
        input data_fall
    );

endinterface

`default_nettype wire

/* mbus_line_sampler.sv */
// MBus line sampler
// Brings bus_clk and bus_data into the negp_int domain and derives the
// clock rise and data rise and fall strobes used by the rest of the node

`timescale 1ns/1ps
`default_nettype none

`include "mbus_macros.svh"

module mbus_line_sampler (
    input  logic        negp_int,
    input  logic        RESETn,
    input  logic        bus_clk,
    input  logic        bus_data,
    mbus_line_if.source line
);

    logic [`MBUS_SYNC_STAGES-1:0] clk_sync;
    logic [`MBUS_SYNC_STAGES-1:0] data_sync;
    logic                         clk_s;
    logic                         data_s;

    // Last synchronizer stage
    assign clk_s  = clk_sync[`MBUS_SYNC_STAGES-1];
    assign data_s = data_sync[`MBUS_SYNC_STAGES-1];

    //////////////////////////////
    // Synchronizers
    //////////////////////////////

    // Preset high so an idle bus shows no edge out of reset
    always_ff @(posedge negp_int or negedge RESETn) begin
        if (!RESETn) begin
            clk_sync  <= '1;
            data_sync <= '1;
        end else begin
            clk_sync  <= {clk_sync[`MBUS_SYNC_STAGES-2:0], bus_clk};
            data_sync <= {data_sync[`MBUS_SYNC_STAGES-2:0], bus_data};
        end
    end

    //////////////////////////////
    // Levels and strobes
    //////////////////////////////

    // Level register doubles as the previous sample for edge compare
    always_ff @(posedge negp_int or negedge RESETn) begin
        if (!RESETn) begin
            line.clk_lvl   <= 1'b1;
            line.data_lvl  <= 1'b1;
            line.clk_rise  <= 1'b0;
            line.data_rise <= 1'b0;
            line.data_fall <= 1'b0;
        end else begin
            line.clk_lvl   <= clk_s;
            line.data_lvl  <= data_s;
            line.clk_rise  <= clk_s & ~line.clk_lvl;
            line.data_rise <= data_s & ~line.data_lvl;
            line.data_fall <= ~data_s & line.data_lvl;
        end
    end

endmodule

`default_nettype wire

/* mbus_interjection_detector.sv */
// MBus interjection detector
// Counts alternating data rise and fall edges while bus_clk is high.
// Three rise/fall pairs give a one-cycle interject pulse and set a sticky
// int_flag that stays up until int_flag_clr

`timescale 1ns/1ps
`default_nettype none

`include "mbus_macros.svh"

module mbus_interjection_detector import mbus_pkg::*; (
    input  logic      negp_int,
    input  logic      RESETn,
    mbus_line_if.sink line,
    input  logic      int_flag_clr,
    output logic      interject,
    output logic      int_flag
);

    edge_cnt_t edge_cnt;
    logic      edge_ok;
    logic      last_edge;

    // Rise expected at even counts, fall at odd counts
    assign edge_ok = line.clk_lvl &&
                     (edge_cnt < edge_cnt_t'(`MBUS_INT_EDGES)) &&
                     (edge_cnt[0] ? line.data_fall : line.data_rise);

    // Final edge of the sequence
    assign last_edge = edge_ok && (edge_cnt == edge_cnt_t'(`MBUS_INT_EDGES - 1));

    //////////////////////////////
    // Edge counter
    //////////////////////////////

    // Count restarts whenever the sampled clock is low
    always_ff @(posedge negp_int or negedge RESETn) begin
        if (!RESETn) begin
            edge_cnt <= '0;
        end else if (!line.clk_lvl) begin
            edge_cnt <= '0;
        end else if (edge_ok) begin
            edge_cnt <= edge_cnt + edge_cnt_t'(1);
        end
    end

    //////////////////////////////
    // Pulse and sticky flag
    //////////////////////////////

    always_ff @(posedge negp_int or negedge RESETn) begin
        if (!RESETn) begin
            interject <= 1'b0;
            int_flag  <= 1'b0;
        end else begin
            interject <= last_edge;
            // New interjection wins over a clear in the same cycle
            if (last_edge) begin
                int_flag <= 1'b1;
            end else if (int_flag_clr) begin
                int_flag <= 1'b0;
            end
        end
    end

    // Pulse lands while the clock is still high on the sampled line
    a_int_clk_high: assert property (@(posedge negp_int) disable iff (!RESETn)
        interject |-> line.clk_lvl);

    // Counter saturates at the interjection count
    a_cnt_range: assert property (@(posedge negp_int) disable iff (!RESETn)
        edge_cnt <= edge_cnt_t'(`MBUS_INT_EDGES));

endmodule

`default_nettype wire

/* mbus_rx_frame.sv */
// MBus receive frame decoder
// Detects the start condition, shifts bits MSB first on each clock rise,
// matches the address byte against node_addr and emits data bytes.
// An interjection ends the frame with rx_end and the rx_ok status

`timescale 1ns/1ps
`default_nettype none

`include "mbus_macros.svh"

module mbus_rx_frame import mbus_pkg::*; (
    input  logic      negp_int,
    input  logic      RESETn,
    mbus_line_if.sink line,
    input  logic      interject,
    input  bus_byte_t node_addr,
    output bus_byte_t rx_data,
    output logic      rx_valid,
    output logic      rx_end,
    output logic      rx_ok
);

    rx_state_t state;
    bus_byte_t shreg;
    bus_byte_t shift_nxt;
    bit_cnt_t  bit_cnt;
    logic      got_byte;
    logic      active;
    logic      byte_done;

    // Byte as it looks after the current bit
    assign shift_nxt = {shreg[`MBUS_BYTE_W-2:0], line.data_lvl};

    assign active    = (state == ADDR) || (state == DATA) || (state == SKIP);

    // Eighth bit of a byte arriving
    assign byte_done = line.clk_rise && (bit_cnt == bit_cnt_t'(`MBUS_BYTE_W - 1));

    //////////////////////////////
    // Frame FSM
    //////////////////////////////

    always_ff @(posedge negp_int or negedge RESETn) begin
        if (!RESETn) begin
            state    <= IDLE;
            bit_cnt  <= '0;
            got_byte <= 1'b0;
            rx_valid <= 1'b0;
            rx_end   <= 1'b0;
            rx_ok    <= 1'b0;
        end else begin
            // Single-cycle outputs
            rx_valid <= 1'b0;
            rx_end   <= 1'b0;
            case (state)
                IDLE: begin
                    // Start condition is data falling under a high clock
                    if (line.clk_lvl && line.data_fall) begin
                        state    <= ADDR;
                        bit_cnt  <= '0;
                        got_byte <= 1'b0;
                        rx_ok    <= 1'b0;
                    end
                end
                ADDR, DATA, SKIP: begin
                    if (interject) begin
                        // Good frame needs a match, a byte and no leftover bits
                        rx_end <= 1'b1;
                        rx_ok  <= (state == DATA) && got_byte && (bit_cnt == '0);
                        state  <= WAIT_IDLE;
                    end else if (line.clk_rise) begin
                        // Wraps to zero at the byte boundary
                        bit_cnt <= bit_cnt + bit_cnt_t'(1);
                        if (byte_done) begin
                            if (state == ADDR) begin
                                state <= (shift_nxt == node_addr) ? DATA : SKIP;
                            end else if (state == DATA) begin
                                rx_valid <= 1'b1;
                                got_byte <= 1'b1;
                            end
                        end
                    end
                end
                WAIT_IDLE: begin
                    // Clock must drop before another start is taken
                    if (!line.clk_lvl) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // Shift and byte registers
    //////////////////////////////

    always_ff @(posedge negp_int) begin
        if (active && line.clk_rise) begin
            shreg <= shift_nxt;
        end
        // Same qualifier as rx_valid above
        if ((state == DATA) && byte_done && !interject) begin
            rx_data <= shift_nxt;
        end
    end

    // Bytes only come out of a frame addressed to this node
    a_valid_in_data: assert property (@(posedge negp_int) disable iff (!RESETn)
        rx_valid |-> $past(state == DATA));

    // Byte and end reports stay apart
    a_valid_end_excl: assert property (@(posedge negp_int) disable iff (!RESETn)
        !(rx_valid && rx_end));

endmodule

`default_nettype wire

/* mbus_rx_node.sv */
// MBus receive-only member node
// Line sampler, interjection detector and frame decoder joined by the
// sampled line group. Bytes and end status leave as plain ports

`timescale 1ns/1ps
`default_nettype none

module mbus_rx_node (
    input  logic       negp_int,
    input  logic       RESETn,
    input  logic       bus_clk,
    input  logic       bus_data,
    input  logic [7:0] node_addr,
    input  logic       int_flag_clr,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       rx_end,
    output logic       rx_ok,
    output logic       int_flag
);

    // Detector to decoder end-of-frame pulse
    logic interject;

    // Sampled bus levels and strobes
    mbus_line_if line_i ();

    mbus_line_sampler sampler_i (
        .negp_int (negp_int),
        .RESETn   (RESETn),
        .bus_clk  (bus_clk),
        .bus_data (bus_data),
        .line     (line_i.source)
    );

    mbus_interjection_detector detector_i (
        .negp_int     (negp_int),
        .RESETn       (RESETn),
        .line         (line_i.sink),
        .int_flag_clr (int_flag_clr),
        .interject    (interject),
        .int_flag     (int_flag)
    );

    mbus_rx_frame frame_i (
        .negp_int  (negp_int),
        .RESETn    (RESETn),
        .line      (line_i.sink),
        .interject (interject),
        .node_addr (node_addr),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .rx_end    (rx_end),
        .rx_ok     (rx_ok)
    );

endmodule

`default_nettype wire

/* tb_mbus_rx_node.sv */
// MBus receive node testbench
// Reads frame descriptions from the pattern file, drives bus_clk and bus_data
// and checks bytes, end status and the sticky interjection flag

`timescale 1ns/1ps
`default_nettype none

`include "mbus_macros.svh"

module tb_mbus_rx_node import mbus_pkg::*; ();

    localparam int WAIT_LIMIT = 400;

    logic      negp_int;
    logic      RESETn;
    logic      bus_clk;
    logic      bus_data;
    bus_byte_t node_addr;
    logic      int_flag_clr;
    bus_byte_t rx_data;
    logic      rx_valid;
    logic      rx_end;
    logic      rx_ok;
    logic      int_flag;

    logic [31:0] lfsr_state;
    int          check_errs;
    int          timeout_errs;
    int          end_cnt;
    logic        end_ok;
    logic        frame_bits[$];
    bus_byte_t   got_bytes[$];
    bus_byte_t   exp_bytes[$];
    logic        exp_ok;

    mbus_rx_node dut_i (
        .negp_int     (negp_int),
        .RESETn       (RESETn),
        .bus_clk      (bus_clk),
        .bus_data     (bus_data),
        .node_addr    (node_addr),
        .int_flag_clr (int_flag_clr),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .rx_end       (rx_end),
        .rx_ok        (rx_ok),
        .int_flag     (int_flag)
    );

    initial negp_int = 1'b0;
    always #2 negp_int = ~negp_int;

    // Output monitor, sampled away from the active edge
    always @(negedge negp_int) begin
        if (RESETn) begin
            if (rx_valid) begin
                got_bytes.push_back(rx_data);
            end
            if (rx_end) begin
                end_cnt = end_cnt + 1;
                end_ok  = rx_ok;
            end
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic flag_mismatch(input string msg);
        check_errs++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic next_rand_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    // 8 cycles plus 0 to 7 random extra
    task automatic half_period();
        int extra;
        extra = 0;
        for (int i = 0; i < 3; i++) begin
            extra = (extra << 1) | int'(next_rand_bit());
        end
        repeat (8 + extra) @(negedge negp_int);
    endtask

    task automatic send_start();
        bus_data = 1'b0;
        half_period();
    endtask

    // Data changes mid low phase, taken on the clock rise
    task automatic send_bit(input logic b);
        bus_clk = 1'b0;
        half_period();
        bus_data = b;
        half_period();
        bus_clk = 1'b1;
        half_period();
    endtask

    // Rise/fall pairs under a high clock, starting from data low
    task automatic send_pairs(input int pairs);
        if (bus_data) begin
            bus_data = 1'b0;
            half_period();
        end
        repeat (pairs) begin
            bus_data = 1'b1;
            half_period();
            bus_data = 1'b0;
            half_period();
        end
    endtask

    // Back to idle high without a start condition
    task automatic release_bus();
        bus_clk = 1'b0;
        half_period();
        bus_data = 1'b1;
        half_period();
        bus_clk = 1'b1;
        half_period();
    endtask

    task automatic push_byte(input bus_byte_t v, input int count);
        for (int i = 0; i < count; i++) begin
            frame_bits.push_back(v[7-i]);
        end
    endtask

    // Reference model: address match, whole bytes, no leftover bits
    task automatic compute_expected(input bus_byte_t naddr);
        bus_byte_t acc;
        int        n;
        exp_bytes.delete();
        exp_ok = 1'b0;
        acc = '0;
        n = frame_bits.size();
        if (n >= 8) begin
            for (int i = 0; i < 8; i++) begin
                acc = {acc[6:0], frame_bits[i]};
            end
            if (acc == naddr) begin
                for (int k = 8; k + 8 <= n; k += 8) begin
                    for (int i = 0; i < 8; i++) begin
                        acc = {acc[6:0], frame_bits[k+i]};
                    end
                    exp_bytes.push_back(acc);
                end
                exp_ok = (exp_bytes.size() > 0) && (n % 8 == 0);
            end
        end
    endtask

    task automatic wait_end(input int target);
        int n;
        n = 0;
        while (end_cnt < target && n < WAIT_LIMIT) begin
            @(negedge negp_int);
            n++;
        end
        if (end_cnt < target) begin
            timeout_errs++;
            $display("Timeout: rx_end never arrived after the interjection");
        end
    endtask

    task automatic wait_flag(input logic level);
        int n;
        n = 0;
        while (int_flag !== level && n < WAIT_LIMIT) begin
            @(negedge negp_int);
            n++;
        end
        if (int_flag !== level) begin
            timeout_errs++;
            $display("Timeout: int_flag never went to %0b", level);
        end
    endtask

    // Quiet bus, no strobes and a steady flag
    task automatic hold_quiet(input int cycles, input logic flag_exp, input logic chk_ok);
        repeat (cycles) begin
            @(negedge negp_int);
            assert (!rx_valid && !rx_end && int_flag == flag_exp && !(chk_ok && rx_ok))
            else flag_mismatch($sformatf("idle outputs valid=%0b end=%0b ok=%0b flag=%0b",
                                         rx_valid, rx_end, rx_ok, int_flag));
        end
    endtask

    //////////////////////////////
    // Frame and clear sequences
    //////////////////////////////

    task automatic run_frame(input logic glitch);
        int   ends_before;
        logic flag_before;
        ends_before = end_cnt;
        flag_before = int_flag;
        got_bytes.delete();
        send_start();
        foreach (frame_bits[i]) begin
            send_bit(frame_bits[i]);
        end
        if (glitch) begin
            // Short burst, then the clock drops and one more bit follows
            send_pairs(`MBUS_INT_EDGES / 2 - 1);
            send_bit(1'b0);
            frame_bits.push_back(1'b0);
            assert (end_cnt == ends_before && int_flag == flag_before)
            else flag_mismatch("short data burst was taken as an interjection");
        end
        compute_expected(node_addr);
        send_pairs(`MBUS_INT_EDGES / 2);
        release_bus();
        wait_end(ends_before + 1);
        assert (got_bytes.size() == exp_bytes.size())
        else flag_mismatch($sformatf("got %0d bytes, expected %0d",
                                     got_bytes.size(), exp_bytes.size()));
        foreach (exp_bytes[i]) begin
            if (i < got_bytes.size()) begin
                assert (got_bytes[i] == exp_bytes[i])
                else flag_mismatch($sformatf("byte %0d is %h, expected %h",
                                             i, got_bytes[i], exp_bytes[i]));
            end
        end
        assert (end_ok == exp_ok)
        else flag_mismatch($sformatf("rx_ok %0b, expected %0b", end_ok, exp_ok));
        wait_flag(1'b1);
        hold_quiet(40, 1'b1, 1'b0);
        assert (end_cnt == ends_before + 1)
        else flag_mismatch($sformatf("%0d rx_end pulses, expected 1", end_cnt - ends_before));
    endtask

    task automatic run_clear();
        assert (int_flag)
        else flag_mismatch("int_flag low before the clear");
        int_flag_clr = 1'b1;
        @(negedge negp_int);
        int_flag_clr = 1'b0;
        wait_flag(1'b0);
        hold_quiet(40, 1'b0, 1'b0);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        string      line;
        int         fd;
        int         rc;
        int         nbytes;
        int         nbits;
        logic [7:0] kind;
        bus_byte_t  naddr;
        bus_byte_t  faddr;
        bus_byte_t  d[4];
        RESETn       = 1'b0;
        bus_clk      = 1'b1;
        bus_data     = 1'b1;
        node_addr    = '0;
        int_flag_clr = 1'b0;
        lfsr_state   = 32'h2d4b;
        check_errs   = 0;
        timeout_errs = 0;
        end_cnt      = 0;
        end_ok       = 1'b0;
        repeat (10) @(negedge negp_int);
        RESETn = 1'b1;
        hold_quiet(40, 1'b0, 1'b1);
        fd = $fopen("mbus_rx_patterns.txt", "r");
        if (fd == 0) begin
            check_errs++;
            $display("Could not open the pattern file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                rc = $sscanf(line, "%c %h %h %d %d %h %h %h %h", kind, naddr, faddr,
                             nbytes, nbits, d[0], d[1], d[2], d[3]);
                if (rc != 9 || nbytes > 4 || (nbits > 0 && nbytes > 3)) begin
                    check_errs++;
                    $display("Pattern line could not be read: %s", line);
                    continue;
                end
                if (kind == "C") begin
                    run_clear();
                end else if (kind == "F" || kind == "G") begin
                    node_addr = naddr;
                    frame_bits.delete();
                    push_byte(faddr, 8);
                    for (int i = 0; i < nbytes; i++) begin
                        push_byte(d[i], 8);
                    end
                    if (nbits > 0) begin
                        push_byte(d[nbytes], nbits);
                    end
                    run_frame(kind == "G");
                end else begin
                    check_errs++;
                    $display("Unknown test kind in pattern line: %s", line);
                end
            end
            $fclose(fd);
        end
        $display("Errors: %0d check, %0d timeout", check_errs, timeout_errs);
        if (check_errs == 0 && timeout_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mbus_rx_patterns.txt */
# kind node_addr frame_addr data_bytes partial_bits d0 d1 d2 d3 (hex), partial bits MSB first
# F frame, G frame with a short burst before its end, C clear of int_flag (other columns unused)
F 5a 5a 2 0 a5 3c 00 00
C 00 00 0 0 00 00 00 00
F 5a 77 2 0 11 22 00 00
C 00 00 0 0 00 00 00 00
F 5a 5a 1 5 e1 b0 00 00
C 00 00 0 0 00 00 00 00
G 31 31 1 0 c3 00 00 00
F 31 31 3 0 01 80 ff 00
F 31 31 4 0 de ad be ef
C 00 00 0 0 00 00 00 00
F 00 00 0 0 00 00 00 00
C 00 00 0 0 00 00 00 00
G 31 31 1 7 c3 fe 00 00
F a0 a0 1 0 55 00 00 00
C 00 00 0 0 00 00 00 00

/* sources.f */
+incdir+.
mbus_pkg.sv
mbus_line_if.sv
mbus_line_sampler.sv
mbus_interjection_detector.sv
mbus_rx_frame.sv
mbus_rx_node.sv
tb_mbus_rx_node.sv

/* Makefile */
# Verilator flow for the MBus receive node

VERILATOR  ?= verilator
FILELIST   ?= sources.f
TB_TOP     ?= tb_mbus_rx_node
RTL_TOP    ?= mbus_rx_node
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= all tests passed
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
